/* uart_core.f */
+incdir+include
logic/uart_line_pkg.sv
logic/uart_bus_pkg.sv
logic/baud_tick_gen.sv
logic/uart_receiver.sv
logic/uart_transmitter.sv
logic/uart_wb_regs.sv
logic/uart_core.sv
verification/tb_clock_gen.sv
verification/uart_core_asserts.sv
verification/uart_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it, and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module uart_core_tb \
	-f uart_core.f -o uart_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Raise the error limit so assertion failures do not stop the run early
sim_output=$(./obj_dir/uart_core_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

/* verification/uart_core_tb.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_core_tb;
	import uart_bus_pkg::*;

	typedef enum logic [1:0] {
		mode_loopback,
		mode_bad_stop,
		mode_glitch,
		mode_overrun
	} row_mode_t;

	typedef struct packed {
		row_mode_t mode;
		logic [7:0] data;        // Byte on the line, second byte for overrun
		logic [3:0] exp_status;  // tx_busy bit not compared
		logic [7:0] exp_data;
	} row_t;

	localparam int num_rows = 9;
	localparam int tb_div = 3;  // Divisor used for all frames
	localparam int frame_ticks = (`UART_DATA_BITS + 2) * `UART_OVERSAMPLE;
	localparam int timeout_cycles = num_rows * 2 * frame_ticks * tb_div * 2;
	localparam logic [3:0] st_rx_valid = 4'b0001;  // STATUS bit layout
	localparam logic [3:0] st_overrun = 4'b0100;
	localparam logic [3:0] st_frame_error = 4'b1000;

	logic clk;
	logic reset;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	logic rx_line;
	logic tx_line;
	logic line_drv;   // Testbench side of the serial line
	logic loop_sel;   // 1 routes tx back to rx
	row_t rows [num_rows];
	string row_names [num_rows];
	int row_count = 0;
	int value_errors = 0;
	int assert_errors = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'hb5e7114d;

	assign rx_line = loop_sel ? tx_line : line_drv;

	tb_clock_gen u_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	uart_core u_dut (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.rx(rx_line),
		.tx(tx_line)
	);

	bind uart_core uart_core_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.tx_busy(tx_busy),
		.tx(tx)
	);

	////////////////////////////////////////
	// Helpers, all start and end 1 ns after an edge
	////////////////////////////////////////

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];  // Upper bits, better spread
	endfunction

	task automatic add_row(input string name, input row_mode_t mode, input logic [7:0] data);
		row_t r;
		r.mode = mode;
		r.data = data;
		r.exp_data = data;
		case (mode)
			mode_loopback: r.exp_status = st_rx_valid;
			mode_bad_stop: r.exp_status = st_rx_valid | st_frame_error;
			mode_overrun: r.exp_status = st_rx_valid | st_overrun;
			default: r.exp_status = 4'b0000;  // Glitch leaves nothing
		endcase
		rows[row_count] = r;
		row_names[row_count] = name;
		row_count++;
	endtask

	task automatic idle_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_ack();
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!bus_rsp.ack);
	endtask

	task automatic bus_write(input reg_addr_t adr, input logic [31:0] dat);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = 1'b1;
		bus_req.adr = adr;
		bus_req.dat = dat;
		wait_ack();
		bus_req = '0;  // End of cycle
	endtask

	task automatic bus_read(input reg_addr_t adr, output logic [31:0] dat);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = 1'b0;
		bus_req.adr = adr;
		bus_req.dat = '0;
		wait_ack();
		dat = bus_rsp.dat;  // Valid with ack
		bus_req = '0;
	endtask

	task automatic poll_rx_valid(output logic [31:0] status);
		do
			bus_read(reg_status, status);
		while (!status[0]);
	endtask

	task automatic wait_tx_idle();
		logic [31:0] status;
		do
			bus_read(reg_status, status);
		while (status[1]);
	endtask

	task automatic drive_bit(input logic level, input int ticks);
		line_drv = level;
		idle_clocks(ticks * tb_div);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic stop);
		drive_bit(1'b0, `UART_OVERSAMPLE);  // Start bit
		for (int b = 0; b < `UART_DATA_BITS; b++)
			drive_bit(data[b], `UART_OVERSAMPLE);  // LSB first
		drive_bit(stop, `UART_OVERSAMPLE);
		drive_bit(1'b1, `UART_OVERSAMPLE);  // Idle gap
	endtask

	////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////

	initial
	begin
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a bus or status wait never finished", cycle_count);
		$display("Checks failed");
		$finish;
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] status;
		row_t row;
		bus_req = '0;
		line_drv = 1'b1;
		loop_sel = 1'b0;
		add_row("loopback 55", mode_loopback, 8'h55);
		add_row("loopback c3", mode_loopback, 8'hc3);
		add_row("loopback random a", mode_loopback, next_random());
		add_row("loopback random b", mode_loopback, next_random());
		add_row("bad stop a5", mode_bad_stop, 8'ha5);
		add_row("bad stop random", mode_bad_stop, next_random());
		add_row("overrun 3c", mode_overrun, 8'h3c);
		add_row("overrun random", mode_overrun, next_random());
		add_row("false start", mode_glitch, 8'h00);
		wait (!reset);
		@(posedge clk);
		#1;

		// Reset values
		bus_read(reg_status, rdata);
		if (rdata !== 32'h0)
		begin
			$display("FAILED reset status: expected %h, actual %h", 32'h0, rdata);
			value_errors++;
		end
		bus_read(reg_divisor, rdata);
		if (rdata !== 32'(`UART_DIV_RESET))
		begin
			$display("FAILED reset divisor: expected %h, actual %h", 32'(`UART_DIV_RESET), rdata);
			value_errors++;
		end
		bus_write(reg_divisor, 32'(tb_div));
		bus_read(reg_divisor, rdata);
		if (rdata !== 32'(tb_div))
		begin
			$display("FAILED divisor readback: expected %h, actual %h", 32'(tb_div), rdata);
			value_errors++;
		end

		for (int i = 0; i < num_rows; i++)
		begin
			row = rows[i];
			loop_sel = (row.mode == mode_loopback);
			case (row.mode)
				mode_loopback:
				begin
					bus_write(reg_data, {24'd0, row.data});
					bus_write(reg_data, {24'd0, ~row.data});  // Busy, must be dropped
				end
				mode_bad_stop: send_frame(row.data, 1'b0);
				mode_overrun:
				begin
					send_frame(~row.data, 1'b1);  // Left unread
					send_frame(row.data, 1'b1);
				end
				default:
				begin
					drive_bit(1'b0, 4);  // Short low pulse
					drive_bit(1'b1, frame_ticks);
				end
			endcase
			if (row.mode != mode_glitch)
			begin
				poll_rx_valid(status);
				if ((status & ~32'h2) !== {28'd0, row.exp_status})
				begin
					$display("FAILED %s status: expected %h, actual %h",
						row_names[i], {28'd0, row.exp_status}, status & ~32'h2);
					value_errors++;
				end
				bus_read(reg_data, rdata);
				if (rdata !== {24'd0, row.exp_data})
				begin
					$display("FAILED %s data: expected %h, actual %h",
						row_names[i], {24'd0, row.exp_data}, rdata);
					value_errors++;
				end
				wait_tx_idle();
			end
			if (row.mode == mode_loopback)
				idle_clocks(frame_ticks * tb_div);  // Room for a second frame
			bus_read(reg_status, status);
			if (status !== 32'h0)
			begin
				$display("FAILED %s status after: expected %h, actual %h",
					row_names[i], 32'h0, status);
				value_errors++;
			end
		end

		assert_errors = u_dut.u_asserts.fail_count;
		$display("Error counts: %0d value, %0d assertion", value_errors, assert_errors);
		if (value_errors == 0 && assert_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* verification/uart_core_asserts.sv */
`timescale 1ns/1ps

module uart_core_asserts (
	input logic clk,
	input logic reset,
	input uart_bus_pkg::wb_req_t bus_req,
	input uart_bus_pkg::wb_rsp_t bus_rsp,
	input logic tx_busy,
	input logic tx
);
	import uart_bus_pkg::*;

	int fail_count = 0;  // Failed assertions so far

	////////////////////////////////////////
	// Wishbone handshake
	////////////////////////////////////////

	// Ack lasts one cycle
	ack_single: assert property (@(posedge clk) disable iff (reset)
		bus_rsp.ack |=> !bus_rsp.ack)
	else
	begin
		$error("ack stayed high for two cycles");
		fail_count++;
	end

	// Ack only answers a request
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(bus_rsp.ack) |-> $past(bus_req.cyc && bus_req.stb))
	else
	begin
		$error("ack rose without cyc and stb");
		fail_count++;
	end

	////////////////////////////////////////
	// Serial line
	////////////////////////////////////////

	tx_idle_high: assert property (@(posedge clk) disable iff (reset)
		!tx_busy |-> tx)  // Line marks while idle
	else
	begin
		$error("tx low while transmitter idle");
		fail_count++;
	end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);  // Four edges in reset
		#1 reset = 1'b0;
	end

endmodule

/* logic/uart_core.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_core (
	input logic clk,
	input logic reset,
	input uart_bus_pkg::wb_req_t bus_req,   // From bus master
	output uart_bus_pkg::wb_rsp_t bus_rsp,
	input logic rx,                         // Serial in, async
	output logic tx                         // Serial out
);
	import uart_bus_pkg::*;
	import uart_line_pkg::*;

	logic [`UART_DIV_BITS-1:0] divisor;
	logic tick;                             // Shared by RX and TX
	logic rx_done;
	rx_frame_t rx_frame;
	logic tx_start;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic tx_busy;

	baud_tick_gen u_baud_tick_gen (
		.clk(clk),
		.reset(reset),
		.divisor(divisor),
		.tick(tick)
	);

	uart_receiver u_uart_receiver (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.rx(rx),
		.rx_done(rx_done),
		.rx_frame(rx_frame)
	);

	uart_transmitter u_uart_transmitter (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.tx(tx)
	);

	// Bus side, owns divisor and flags
	uart_wb_regs u_uart_wb_regs (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.rx_done(rx_done),
		.rx_frame(rx_frame),
		.tx_busy(tx_busy),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.divisor(divisor)
	);

endmodule

/* logic/uart_wb_regs.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_wb_regs (
	input logic clk,
	input logic reset,
	input uart_bus_pkg::wb_req_t bus_req,
	output uart_bus_pkg::wb_rsp_t bus_rsp,
	input logic rx_done,                            // New frame from receiver
	input uart_line_pkg::rx_frame_t rx_frame,
	input logic tx_busy,
	output logic tx_start,                          // One clk pulse
	output logic [`UART_DATA_BITS-1:0] tx_data,
	output logic [`UART_DIV_BITS-1:0] divisor
);
	import uart_bus_pkg::*;
	import uart_line_pkg::*;

	reg_addr_t addr;
	logic ack;
	logic seen;                                 // New access this cycle
	logic wr_data;
	logic rd_data;
	logic rd_status;
	logic [31:0] rdata;
	logic [`UART_DATA_BITS-1:0] rx_byte;        // Holding register
	logic rx_valid;
	logic overrun;
	logic frame_error;

	assign addr = reg_addr_t'(bus_req.adr);
	assign seen = bus_req.cyc && bus_req.stb && !ack;  // Ack low, so one ack per access
	assign wr_data = seen && bus_req.we && addr == reg_data;
	assign rd_data = seen && !bus_req.we && addr == reg_data;
	assign rd_status = seen && !bus_req.we && addr == reg_status;

	assign bus_rsp.ack = ack;
	assign bus_rsp.dat = rdata;

	////////////////////////////////////////
	// Bus handshake and control registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			tx_start <= 1'b0;
			rx_valid <= 1'b0;
			overrun <= 1'b0;
			frame_error <= 1'b0;
			divisor <= `UART_DIV_BITS'(`UART_DIV_RESET);
		end
		else
		begin
			ack <= seen;
			tx_start <= wr_data && !tx_busy;  // Write while busy is dropped
			if (seen && bus_req.we && addr == reg_divisor)
				divisor <= bus_req.dat[`UART_DIV_BITS-1:0];
			// Read clears first, new frame wins below
			if (rd_data)
				rx_valid <= 1'b0;
			if (rd_status)
			begin
				overrun <= 1'b0;
				frame_error <= 1'b0;
			end
			if (rx_done)
			begin
				rx_valid <= 1'b1;
				if (rx_valid && !rd_data)
					overrun <= 1'b1;   // Unread byte lost
				if (rx_frame.frame_error)
					frame_error <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Payload registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rx_done)
			rx_byte <= rx_frame.data;  // Overwrites on overrun
		if (wr_data && !tx_busy)
			tx_data <= bus_req.dat[`UART_DATA_BITS-1:0];
		if (seen)
		begin
			case (addr)
				reg_data: rdata <= 32'(rx_byte);
				reg_status: rdata <= {28'd0, frame_error, overrun, tx_busy, rx_valid};
				reg_divisor: rdata <= 32'(divisor);
				default: rdata <= '0;  // Unmapped
			endcase
		end
	end

endmodule

/* logic/uart_transmitter.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_transmitter (
	input logic clk,
	input logic reset,
	input logic tick,                          // Oversample strobe
	input logic tx_start,                      // One clk pulse, ignored while busy
	input logic [`UART_DATA_BITS-1:0] tx_data,
	output logic tx_busy,
	output logic tx                            // Serial line, idles high
);
	import uart_line_pkg::*;

	localparam int tick_w = $clog2(`UART_OVERSAMPLE);
	localparam int idx_w = $clog2(`UART_DATA_BITS);
	localparam logic [tick_w-1:0] last_tick = tick_w'(`UART_OVERSAMPLE - 1);
	localparam logic [idx_w-1:0] last_bit = idx_w'(`UART_DATA_BITS - 1);

	tx_state_t state;
	logic wait_tick;                         // Start bit not yet on the line
	logic [tick_w-1:0] tick_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [`UART_DATA_BITS-1:0] shift_reg;
	logic bit_end;

	assign bit_end = tick && (tick_cnt == last_tick);  // 16 ticks done
	assign tx_busy = (state != tx_st_idle);            // High the edge after tx_start

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= tx_st_idle;
			wait_tick <= 1'b0;
			tick_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end
		else
		begin
			if (tick)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				tx_st_idle:
				begin
					tx <= 1'b1;
					if (tx_start)
					begin
						wait_tick <= 1'b1;
						state <= tx_st_start;
					end
				end
				tx_st_start:
					if (wait_tick)
					begin
						if (tick)
						begin
							tx <= 1'b0;  // Start bit begins on this tick
							tick_cnt <= '0;
							wait_tick <= 1'b0;
						end
					end
					else if (bit_end)
					begin
						tx <= shift_reg[0];
						bit_idx <= '0;
						state <= tx_st_data;
					end
				tx_st_data:
					if (bit_end)
					begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == last_bit)
						begin
							tx <= 1'b1;  // Stop bit
							state <= tx_st_stop;
						end
						else
							tx <= shift_reg[0];
					end
				tx_st_stop:
					if (bit_end)
						state <= tx_st_idle;  // Busy drops here
				default:
					state <= tx_st_idle;
			endcase
		end
	end

	// Byte latch and shift, payload only
	always_ff @(posedge clk)
	begin
		if (state == tx_st_idle && tx_start)
			shift_reg <= tx_data;
		else if (bit_end && (state == tx_st_data || (state == tx_st_start && !wait_tick)))
			shift_reg <= shift_reg >> 1;  // Next bit to [0]
	end

endmodule

/* logic/uart_receiver.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_receiver (
	input logic clk,
	input logic reset,
	input logic tick,                          // Oversample strobe
	input logic rx,                            // Async line
	output logic rx_done,                      // One pulse per frame
	output uart_line_pkg::rx_frame_t rx_frame
);
	import uart_line_pkg::*;

	localparam int tick_w = $clog2(`UART_OVERSAMPLE);
	localparam int idx_w = $clog2(`UART_DATA_BITS);
	localparam logic [tick_w-1:0] mid_tick = tick_w'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [tick_w-1:0] last_tick = tick_w'(`UART_OVERSAMPLE - 1);
	localparam logic [idx_w-1:0] last_bit = idx_w'(`UART_DATA_BITS - 1);

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_last;                           // Previous synced level, edge detect
	logic [tick_w-1:0] tick_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [`UART_DATA_BITS-1:0] shift_reg;
	logic sample;

	// Bit middle reached, 16 ticks after previous sample
	assign sample = tick && (tick_cnt == last_tick);

	////////////////////////////////////////
	// Input synchronizer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;  // Line idles high
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	////////////////////////////////////////
	// Receive FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= rx_st_idle;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			if (tick)
				tick_cnt <= tick_cnt + 1'b1;  // Wraps at 16
			case (state)
				rx_st_idle:
				begin
					tick_cnt <= '0;
					// Falling edge only, a line held low after a bad stop is ignored
					if (rx_last && !rx_sync)
						state <= rx_st_start;
				end
				rx_st_start:
					if (tick && tick_cnt == mid_tick)
					begin
						tick_cnt <= '0;  // Realign to bit middle
						bit_idx <= '0;
						state <= rx_sync ? rx_st_idle : rx_st_data;  // High again, glitch
					end
				rx_st_data:
					if (sample)
					begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == last_bit)
							state <= rx_st_stop;
					end
				rx_st_stop:
					if (sample)
					begin
						rx_done <= 1'b1;
						state <= rx_st_idle;  // Back to idle mid stop bit
					end
				default:
					state <= rx_st_idle;
			endcase
		end
	end

	// Shift register and frame output, qualified by state
	always_ff @(posedge clk)
	begin
		if (sample && state == rx_st_data)
			shift_reg <= {rx_sync, shift_reg[`UART_DATA_BITS-1:1]};  // LSB first
		if (sample && state == rx_st_stop)
		begin
			rx_frame.data <= shift_reg;
			rx_frame.frame_error <= !rx_sync;  // Stop must be high
		end
	end

endmodule

/* logic/baud_tick_gen.sv */
`timescale 1ns/1ps
`include "uart_params.svh"

module baud_tick_gen (
	input logic clk,
	input logic reset,
	input logic [`UART_DIV_BITS-1:0] divisor,  // Clocks per tick
	output logic tick                          // One clk wide
);

	logic [`UART_DIV_BITS-1:0] count;
	logic [`UART_DIV_BITS-1:0] reload;

	// Zero divisor behaves as 1, so tick every clock
	assign reload = (divisor == '0) ? '0 : divisor - 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= reload;  // New divisor picked up here
			tick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* logic/uart_bus_pkg.sv */
package uart_bus_pkg;

	// Wishbone classic request, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;   // Word address
		logic [31:0] dat;  // Write data
	} wb_req_t;

	// Wishbone classic response, slave side
	typedef struct packed {
		logic ack;         // One cycle per access
		logic [31:0] dat;  // Read data, valid with ack
	} wb_rsp_t;

	// Register map
	typedef enum logic [1:0] {
		reg_data = 2'd0,    // RX byte on read, TX byte on write
		reg_status = 2'd1,  // Flags, read clears sticky bits
		reg_divisor = 2'd2  // Clocks per oversample tick
	} reg_addr_t;

	// Address 3 unmapped

endpackage

/* logic/uart_line_pkg.sv */
`include "uart_params.svh"

package uart_line_pkg;

	// Receiver FSM
	typedef enum logic [1:0] {
		rx_st_idle,   // Waiting for falling edge
		rx_st_start,  // Counting to middle of start bit
		rx_st_data,   // Sampling data bits
		rx_st_stop    // Sampling stop bit
	} rx_state_t;

	// Transmitter FSM
	typedef enum logic [1:0] {
		tx_st_idle,
		tx_st_start,  // Includes wait for first tick
		tx_st_data,
		tx_st_stop
	} tx_state_t;

	// One received frame, qualified by rx_done
	typedef struct packed {
		logic [`UART_DATA_BITS-1:0] data;  // LSB was first on the line
		logic frame_error;                 // Stop bit sampled low
	} rx_frame_t;

endpackage

/* include/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

////////////////////////////////////////
// Serial frame shape
////////////////////////////////////////

// Oversample ticks per bit
`define UART_OVERSAMPLE 16

// Data bits per frame, no parity
`define UART_DATA_BITS 8

////////////////////////////////////////
// Baud divisor
////////////////////////////////////////

`define UART_DIV_BITS 16   // Divisor register width
`define UART_DIV_RESET 4   // Divisor out of reset

`endif
